/* fec_pkg.sv */
package fec_pkg;

    localparam int SYM_SIZE = 4;                 // bits per field element
    localparam int RS_K     = 4;                 // data symbols per codeword
    localparam int RS_N     = 8;                 // code symbols per codeword
    localparam int POS_W    = $clog2(RS_N);      // width of a code position index

    typedef logic [SYM_SIZE-1:0] sym_t;
    typedef logic [POS_W-1:0]    pos_t;

    // primitive polynomial x^4 + x + 1, top bit dropped during reduction
    localparam logic [SYM_SIZE:0] GF_POLY = 5'b10011;

    function automatic sym_t gf_add(input sym_t a, input sym_t b);
        return a ^ b;
    endfunction

    // shift-and-add multiply, reducing whenever the shifted operand overflows
    function automatic sym_t gf_mul(input sym_t a, input sym_t b);
        sym_t prod;
        sym_t x;
        prod = '0;
        x    = a;
        for (int i = 0; i < SYM_SIZE; i++) begin
            if (b[i]) prod = prod ^ x;
            x = x[SYM_SIZE-1] ? ((x << 1) ^ GF_POLY[SYM_SIZE-1:0]) : (x << 1);
        end
        return prod;
    endfunction

    // inverse of alpha^i is alpha^(15-i), zero maps to zero
    function automatic sym_t gf_inv(input sym_t a);
        case (a)
            4'd1:    return 4'd1;
            4'd2:    return 4'd9;
            4'd3:    return 4'd14;
            4'd4:    return 4'd13;
            4'd5:    return 4'd11;
            4'd6:    return 4'd7;
            4'd7:    return 4'd6;
            4'd8:    return 4'd15;
            4'd9:    return 4'd2;
            4'd10:   return 4'd12;
            4'd11:   return 4'd5;
            4'd12:   return 4'd10;
            4'd13:   return 4'd4;
            4'd14:   return 4'd3;
            4'd15:   return 4'd8;
            default: return 4'd0;
        endcase
    endfunction

    // data rows are the identity; a parity row is the Cauchy row 1/(x_p + y_k),
    // with x_p taken from elements K..N-1 and y_k from elements 0..K-1
    function automatic sym_t gen_coef(input int p, input int k);
        if (p < RS_K) return (p == k) ? sym_t'(1) : sym_t'(0);
        return gf_inv(gf_add(sym_t'(p - RS_K + RS_K), sym_t'(k)));
    endfunction

endpackage

/* rs_encode.sv */
`timescale 1ns/1ps

module rs_encode
    import fec_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    input  sym_t [RS_K-1:0]       msg_in,
    input  logic [RS_N-1:0]       erase_mask,
    input  logic                  in_valid,
    output logic                  in_ready,

    output sym_t [RS_N-1:0]       code_out,
    output logic [RS_N-1:0]       mask_out,
    output logic                  out_valid,
    input  logic                  out_ready
);

    sym_t [RS_N-1:0] code_d;
    logic            accept;

    assign in_ready = out_ready | ~out_valid;  // room when empty or draining
    assign accept   = in_valid & in_ready;

    always_comb begin
        sym_t acc;
        for (int k = 0; k < RS_K; k++) code_d[k] = msg_in[k];  // systematic part
        for (int p = RS_K; p < RS_N; p++) begin
            acc = '0;
            for (int k = 0; k < RS_K; k++) acc = gf_add(acc, gf_mul(gen_coef(p, k), msg_in[k]));
            code_d[p] = acc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) out_valid <= 1'b0;
        else if (accept) out_valid <= 1'b1;
        else if (out_ready) out_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            code_out <= code_d;
            mask_out <= erase_mask;
        end
    end

endmodule

/* erasure_compact.sv */
`timescale 1ns/1ps

module erasure_compact
    import fec_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    input  sym_t [RS_N-1:0]       code_in,
    input  logic [RS_N-1:0]       mask_in,
    input  logic                  in_valid,
    output logic                  in_ready,

    output sym_t [RS_K-1:0]       surv_out,
    output pos_t [RS_K-1:0]       surv_pos,
    output logic [RS_N-1:0]       mask_out,
    output logic                  out_valid,
    input  logic                  out_ready
);

    localparam int CNT_W = $clog2(RS_K) + 1;

    sym_t [RS_K-1:0] surv_d;
    pos_t [RS_K-1:0] pos_d;
    logic            accept;

    assign in_ready = out_ready | ~out_valid;
    assign accept   = in_valid & in_ready;

    // ascending scan, so data survivors always land ahead of parity survivors
    always_comb begin
        logic [CNT_W-1:0] cnt;
        cnt    = '0;
        surv_d = '0;
        pos_d  = '0;
        for (int p = 0; p < RS_N; p++) begin
            if (!mask_in[p] && cnt < CNT_W'(RS_K)) begin
                surv_d[cnt[CNT_W-2:0]] = code_in[p];
                pos_d[cnt[CNT_W-2:0]]  = pos_t'(p);
                cnt = cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) out_valid <= 1'b0;
        else if (accept) out_valid <= 1'b1;
        else if (out_ready) out_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            surv_out <= surv_d;
            surv_pos <= pos_d;
            mask_out <= mask_in;
        end
    end

endmodule

/* h_matrix_solver.sv */
`timescale 1ns/1ps

module h_matrix_solver
    import fec_pkg::*;
(
    input  logic                        clk,
    input  logic                        arst_n,

    input  sym_t [RS_K-1:0]             surv_in,
    input  pos_t [RS_K-1:0]             pos_in,
    input  logic [RS_N-1:0]             mask_in,
    input  logic                        in_valid,
    output logic                        in_ready,

    output sym_t [RS_K-1:0]             surv_out,
    output sym_t [RS_K-1:0][RS_K-1:0]   h_matrix,
    output logic [RS_N-1:0]             err_loc_vec,
    output logic                        out_valid,
    input  logic                        out_ready
);

    localparam int IDX_W = $clog2(RS_K);

    typedef enum logic [2:0] {S_IDLE, S_PIVOT, S_SWAP, S_SCALE, S_ELIM, S_DONE} state_t;

    state_t                    state;
    logic [IDX_W-1:0]          col;
    logic [IDX_W-1:0]          row;
    logic [IDX_W-1:0]          piv_row;
    logic [IDX_W-1:0]          piv_sel;
    sym_t [RS_K-1:0][RS_K-1:0] a_mat;     // generator submatrix, reduced to identity
    sym_t [RS_K-1:0][RS_K-1:0] b_mat;     // starts as identity, ends as the inverse
    sym_t [RS_K-1:0]           surv_q;
    logic [RS_K-1:0]           mask_q;
    sym_t                      piv_inv;
    sym_t                      factor;

    // lowest row at or below the diagonal with a nonzero entry in this column
    always_comb begin
        piv_sel = col;
        for (int r = RS_K-1; r >= 0; r--) begin
            if (r >= int'(col) && a_mat[r][col] != '0) piv_sel = IDX_W'(r);
        end
    end

    assign piv_inv = gf_inv(a_mat[col][col]);
    assign factor  = a_mat[row][col];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            col   <= '0;
            row   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (in_valid) begin
                        state <= S_PIVOT;
                        col   <= '0;
                    end
                end
                S_PIVOT: state <= S_SWAP;
                S_SWAP:  state <= S_SCALE;
                S_SCALE: begin
                    state <= S_ELIM;
                    row   <= '0;
                end
                S_ELIM: begin
                    row <= row + 1'b1;  // one row cleared per cycle
                    if (row == IDX_W'(RS_K-1)) begin
                        if (col == IDX_W'(RS_K-1)) begin
                            state <= S_DONE;
                        end else begin
                            col   <= col + 1'b1;
                            state <= S_PIVOT;
                        end
                    end
                end
                S_DONE:  if (out_ready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (in_valid) begin
                    surv_q <= surv_in;
                    mask_q <= mask_in[RS_K-1:0];
                    for (int r = 0; r < RS_K; r++) begin
                        for (int c = 0; c < RS_K; c++) begin
                            a_mat[r][c] <= gen_coef(int'(pos_in[r]), c);
                            b_mat[r][c] <= (r == c) ? sym_t'(1) : sym_t'(0);
                        end
                    end
                end
            end
            S_PIVOT: piv_row <= piv_sel;
            S_SWAP: begin
                a_mat[col]     <= a_mat[piv_row];
                a_mat[piv_row] <= a_mat[col];
                b_mat[col]     <= b_mat[piv_row];
                b_mat[piv_row] <= b_mat[col];
            end
            S_SCALE: begin
                for (int c = 0; c < RS_K; c++) begin
                    a_mat[col][c] <= gf_mul(a_mat[col][c], piv_inv);
                    b_mat[col][c] <= gf_mul(b_mat[col][c], piv_inv);
                end
            end
            S_ELIM: begin
                if (row != col) begin
                    for (int c = 0; c < RS_K; c++) begin
                        a_mat[row][c] <= gf_add(a_mat[row][c], gf_mul(factor, a_mat[col][c]));
                        b_mat[row][c] <= gf_add(b_mat[row][c], gf_mul(factor, b_mat[col][c]));
                    end
                end
            end
            default: ;
        endcase
    end

    assign in_ready    = (state == S_IDLE);
    assign out_valid   = (state == S_DONE);
    assign surv_out    = surv_q;
    assign h_matrix    = b_mat;  // row i maps the survivors onto data symbol i
    assign err_loc_vec = {{(RS_N-RS_K){1'b0}}, mask_q};

endmodule

/* rs_decode.sv */
`timescale 1ns/1ps

module rs_decode
    import fec_pkg::*;
(
    input  logic                        clk,
    input  logic                        arst_n,

    input  sym_t [RS_K-1:0]             data_in,
    input  sym_t [RS_K-1:0][RS_K-1:0]   h_matrix,
    input  logic [RS_N-1:0]             err_loc_vec,
    input  logic                        data_in_valid,
    output logic                        data_in_ready,

    output sym_t [RS_K-1:0]             data_out,
    output logic                        data_out_valid,
    input  logic                        data_out_ready
);

    localparam int PIPE_STAGES = 2;
    localparam int CNT_W       = $clog2(RS_K) + 1;

    sym_t [PIPE_STAGES-1:0][RS_K-1:0] data_pipe;
    logic [PIPE_STAGES-1:0][RS_N-1:0] err_pipe;
    logic [PIPE_STAGES-1:0]           valid_pipe;
    sym_t [RS_K-1:0][RS_K-1:0]        prod_d;
    sym_t [RS_K-1:0][RS_K-1:0]        prod_q;
    sym_t [RS_K-1:0]                  sum_d;
    sym_t [RS_K-1:0]                  sum_q;
    sym_t [RS_K-1:0]                  out_d;
    logic [RS_K-1:0][CNT_W-1:0]       cnt_d;
    logic [RS_K-1:0][CNT_W-1:0]       cnt_q;
    logic                             pipe_en;

    // everything holds while a result sits unaccepted at the output
    assign pipe_en       = ~(data_out_valid & ~data_out_ready);
    assign data_in_ready = pipe_en;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_pipe     <= '0;
            data_out_valid <= 1'b0;
        end else if (pipe_en) begin
            valid_pipe[0] <= data_in_valid;
            for (int i = 1; i < PIPE_STAGES; i++) valid_pipe[i] <= valid_pipe[i-1];
            data_out_valid <= valid_pipe[PIPE_STAGES-1];
        end
    end

    // stage 0 forms products only for the erased data rows
    always_comb begin
        prod_d = '0;
        for (int i = 0; i < RS_K; i++) begin
            if (err_loc_vec[i]) begin
                for (int k = 0; k < RS_K; k++) prod_d[i][k] = gf_mul(data_in[k], h_matrix[i][k]);
            end
        end
    end

    // stage 1 sums the products; erasures counted from position 0 upward
    always_comb begin
        sum_d = '0;
        for (int i = 0; i < RS_K; i++) begin
            for (int k = 0; k < RS_K; k++) sum_d[i] = gf_add(sum_d[i], prod_q[i][k]);
        end
        cnt_d[0] = CNT_W'(err_pipe[0][0]);
        for (int i = 1; i < RS_K; i++) cnt_d[i] = cnt_d[i-1] + CNT_W'(err_pipe[0][i]);
    end

    // stage 2: an unerased symbol i sits cnt places lower among the survivors
    always_comb begin
        int idx;
        for (int i = 0; i < RS_K; i++) begin
            idx = i - int'(cnt_q[i]);
            if (err_pipe[1][i]) out_d[i] = sum_q[i];
            else out_d[i] = data_pipe[1][idx];
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_en) begin
            data_pipe[0] <= data_in;
            err_pipe[0]  <= err_loc_vec;
            for (int i = 1; i < PIPE_STAGES; i++) begin
                data_pipe[i] <= data_pipe[i-1];
                err_pipe[i]  <= err_pipe[i-1];
            end
            prod_q   <= prod_d;
            sum_q    <= sum_d;
            cnt_q    <= cnt_d;
            data_out <= out_d;
        end
    end

endmodule

/* fec_erasure_top.sv */
`timescale 1ns/1ps

module fec_erasure_top
    import fec_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    input  sym_t [RS_K-1:0]       msg_in,
    input  logic [RS_N-1:0]       erase_mask,
    input  logic                  in_valid,
    output logic                  in_ready,

    output sym_t [RS_K-1:0]       msg_out,
    output logic                  out_valid,
    input  logic                  out_ready
);

    sym_t [RS_N-1:0]           enc_code;
    logic [RS_N-1:0]           enc_mask;
    logic                      enc_valid;
    logic                      enc_ready;

    sym_t [RS_K-1:0]           cmp_surv;
    pos_t [RS_K-1:0]           cmp_pos;
    logic [RS_N-1:0]           cmp_mask;
    logic                      cmp_valid;
    logic                      cmp_ready;

    sym_t [RS_K-1:0]           slv_surv;
    sym_t [RS_K-1:0][RS_K-1:0] slv_h;
    logic [RS_N-1:0]           slv_err;
    logic                      slv_valid;
    logic                      slv_ready;

    rs_encode enc_i (
        .clk, .arst_n, .msg_in, .erase_mask, .in_valid, .in_ready,
        .code_out(enc_code), .mask_out(enc_mask), .out_valid(enc_valid), .out_ready(enc_ready)
    );

    // the erasure step stands in for the channel, dropping marked symbols
    erasure_compact cmp_i (
        .clk, .arst_n,
        .code_in(enc_code), .mask_in(enc_mask), .in_valid(enc_valid), .in_ready(enc_ready),
        .surv_out(cmp_surv), .surv_pos(cmp_pos), .mask_out(cmp_mask),
        .out_valid(cmp_valid), .out_ready(cmp_ready)
    );

    h_matrix_solver slv_i (
        .clk, .arst_n,
        .surv_in(cmp_surv), .pos_in(cmp_pos), .mask_in(cmp_mask),
        .in_valid(cmp_valid), .in_ready(cmp_ready),
        .surv_out(slv_surv), .h_matrix(slv_h), .err_loc_vec(slv_err),
        .out_valid(slv_valid), .out_ready(slv_ready)
    );

    rs_decode dec_i (
        .clk, .arst_n,
        .data_in(slv_surv), .h_matrix(slv_h), .err_loc_vec(slv_err),
        .data_in_valid(slv_valid), .data_in_ready(slv_ready),
        .data_out(msg_out), .data_out_valid(out_valid), .data_out_ready(out_ready)
    );

endmodule

/* tb_fec_erasure.sv */
`timescale 1ns/1ps

module tb_fec_erasure
    import fec_pkg::*;
;

    localparam int TIMEOUT_CYC = 2000;   // cycles any single wait may take
    localparam int N_TBL       = 13;
    localparam int N_RAND      = 40;

    // each row is {message symbols 3..0, erasure mask for positions 7..0}
    localparam logic [23:0] TBL [N_TBL] = '{
        {16'h1234, 8'h00},   // nothing erased
        {16'hfedc, 8'h00},
        {16'h5a0f, 8'h01},   // data only
        {16'h9c3e, 8'h0a},
        {16'h0001, 8'h07},
        {16'hbeef, 8'h0f},   // every data symbol rebuilt from parity
        {16'h4321, 8'h10},   // parity only
        {16'h8765, 8'hf0},
        {16'hc0de, 8'h33},   // mixed with exactly N-K erasures
        {16'ha5a5, 8'h96},
        {16'h7777, 8'h69},
        {16'h0000, 8'hc3},
        {16'hffff, 8'h5a}
    };

    logic                  clk;
    logic                  arst_n;
    sym_t [RS_K-1:0]       msg_in;
    logic [RS_N-1:0]       erase_mask;
    logic                  in_valid;
    logic                  in_ready;
    sym_t [RS_K-1:0]       msg_out;
    logic                  out_valid;
    logic                  out_ready;

    logic [31:0]           lfsr_state;
    logic                  bp_en;        // out_ready follows the LFSR while set
    sym_t [RS_K-1:0]       sb_q[$];      // messages accepted but not yet seen at the output

    fec_erasure_top dut_i (
        .clk, .arst_n, .msg_in, .erase_mask, .in_valid, .in_ready,
        .msg_out, .out_valid, .out_ready
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit taken with the newest bit in bit 0
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_msg(input sym_t [RS_K-1:0] got, input sym_t [RS_K-1:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "message mismatch");
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "level mismatch");
        end
    endtask

    // inputs always change 2 ns after the rising edge
    task automatic next_cycle();
        logic [31:0] rnd;
        @(posedge clk);
        #2;
        if (bp_en) begin
            rnd       = take_bits(1);
            out_ready = rnd[0];
        end
    endtask

    // holds in_valid until the encoder takes the item and samples ready mid-cycle
    task automatic drive_item(input sym_t [RS_K-1:0] msg, input logic [RS_N-1:0] mask);
        int waited;
        waited     = 0;
        msg_in     = msg;
        erase_mask = mask;
        in_valid   = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > TIMEOUT_CYC) abort_run("timed out waiting for in_ready");
            next_cycle();
            @(negedge clk);
        end
        next_cycle();
        sb_q.push_back(msg);
    endtask

    // a transfer seen at the falling edge completes on the next rising edge
    always @(negedge clk) begin
        sym_t [RS_K-1:0] exp_msg;
        if (arst_n && out_valid && out_ready) begin
            if (sb_q.size() == 0) abort_run("an output appeared with no message pending");
            exp_msg = sb_q.pop_front();
            check_msg(msg_out, exp_msg, "msg_out");
        end
    end

    initial begin
        logic [31:0]     rnd;
        sym_t [RS_K-1:0] msg;
        logic [RS_N-1:0] mask;
        int              waited;

        clk        = 1'b0;
        arst_n     = 1'b0;
        msg_in     = '0;
        erase_mask = '0;
        in_valid   = 1'b0;
        out_ready  = 1'b1;
        bp_en      = 1'b0;
        lfsr_state = 32'hadcc_6f58;

        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;

        @(negedge clk);
        check_bit(out_valid, 1'b0, "out_valid after reset");
        waited = 0;
        while (!in_ready) begin
            waited++;
            if (waited > TIMEOUT_CYC) abort_run("in_ready never rose after reset");
            @(negedge clk);
        end
        next_cycle();

        for (int t = 0; t < N_TBL; t++) begin
            drive_item(TBL[t][23:8], TBL[t][7:0]);
        end

        // random burst with the sink stalling at random
        bp_en = 1'b1;
        for (int n = 0; n < N_RAND; n++) begin
            rnd  = take_bits(16);
            msg  = rnd[15:0];
            rnd  = take_bits(RS_N);
            mask = rnd[RS_N-1:0];
            while ($countones(mask) > RS_N - RS_K) begin
                rnd = take_bits(3);
                mask[rnd[2:0]] = 1'b0;
            end
            drive_item(msg, mask);
        end
        in_valid = 1'b0;

        waited = 0;
        while (sb_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT_CYC) abort_run("timed out waiting for the outputs to drain");
            next_cycle();
            #2;
        end
        bp_en     = 1'b0;
        out_ready = 1'b1;
        check_bit(out_valid, 1'b0, "out_valid after drain");

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* vlog.f */
fec_pkg.sv
rs_encode.sv
erasure_compact.sv
h_matrix_solver.sv
rs_decode.sv
fec_erasure_top.sv
tb_fec_erasure.sv

/* Makefile */
TOP = tb_fec_erasure

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

.PHONY: all compile run clean
